// ==== Makefile ====
VERILATOR ?= verilator
TOP := chunky_tb
FILELIST := flist.f
BUILD_DIR := obj_dir
VFLAGS := --binary --timing --assert --timescale 1ns/10ps -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// ==== chunky_chk.sv ====
`default_nettype none
`timescale 1ns/10ps

module chunky_chk (
	input wire i_clock,
	input wire i_rst_n,
	input wire i_valid,
	input wire [31:0] i_data,
	input wire i_ready,
	input wire i_request,
	input wire i_request_ready,
	input wire i_done
);
	// A stalled transfer keeps both valid and its payload
	stall_hold: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		i_valid && !i_ready |=> i_valid && $stable(i_data))
		else $error("valid or data changed while the transfer was stalled");

	request_held: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		i_request && !i_request_ready |=> i_request) // Waiting request stays up
		else $error("memory request dropped before its ready");

	request_gap: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		i_request_ready |=> !i_request) // No new request straight after ready
		else $error("new memory request issued in the cycle after ready");

	done_with_transfer: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		i_done |=> $past(i_valid && i_ready) && !i_valid) // The stream ends with the done pulse
		else $error("frame done pulse not on the last pixel transfer");

endmodule

bind chunky_fetch chunky_chk fetch_chk0 (
	.i_clock(i_clock),
	.i_rst_n(i_rst_n),
	.i_valid(o_word_valid),
	.i_data(o_word),
	.i_ready(i_word_ready),
	.i_request(o_vram_request),
	.i_request_ready(i_vram_ready),
	.i_done(1'b0)
);

bind chunky_expand chunky_chk expand_chk0 (
	.i_clock(i_clock),
	.i_rst_n(i_rst_n),
	.i_valid(o_pixel_valid),
	.i_data({8'h00, o_pixel_rgb}),
	.i_ready(i_pixel_ready),
	.i_request(1'b0),
	.i_request_ready(1'b0),
	.i_done(o_frame_done)
);

`default_nettype wire

// ==== chunky_cpu_port.sv ====
`default_nettype none
`timescale 1ns/10ps
`include "chunky_macros.svh"

module chunky_cpu_port (
	input wire i_clock,
	input wire i_rst_n,

	input wire i_cpu_request,
	input wire i_cpu_rw,
	input wire chunky_pkg::addr_t i_cpu_address,
	input wire chunky_pkg::word_t i_cpu_wdata,
	output chunky_pkg::word_t o_cpu_rdata,
	output logic o_cpu_ready,

	output logic o_wb_request,
	output logic o_wb_rw,
	output chunky_pkg::addr_t o_wb_address,
	output chunky_pkg::word_t o_wb_wdata,
	input wire chunky_pkg::word_t i_wb_rdata,
	input wire i_wb_ready,

	output logic o_pal_we,
	output chunky_pkg::pal_index_t o_pal_index,
	output chunky_pkg::rgb_t o_pal_rgb,

	output chunky_pkg::addr_t o_vram_offset,
	output logic o_frame_start
);
	logic busy;
	logic take;
	logic is_vram;
	logic loc_pending;
	logic loc_is_pal;
	logic loc_ready;
	chunky_pkg::addr_t loc_offset;
	chunky_pkg::word_t loc_rdata;
	chunky_pkg::addr_t cpu_offset;

	assign take = i_cpu_request && !busy;
	assign is_vram = i_cpu_address < `CHUNKY_PALETTE_BASE;
	assign o_cpu_ready = loc_ready || i_wb_ready; // VRAM ack passes straight through
	assign o_cpu_rdata = loc_ready ? loc_rdata : i_wb_rdata;

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			busy <= 1'b0;
			o_wb_request <= 1'b0;
			loc_pending <= 1'b0;
			loc_ready <= 1'b0;
			o_pal_we <= 1'b0;
			o_frame_start <= 1'b0;
			o_vram_offset <= '0;
			cpu_offset <= '0;
		end else begin
			loc_pending <= 1'b0;
			loc_ready <= 1'b0;
			o_pal_we <= 1'b0;
			o_frame_start <= 1'b0;
			if (o_cpu_ready) begin
				busy <= 1'b0;
				o_wb_request <= 1'b0;
			end else if (take) begin
				busy <= 1'b1;
				o_wb_request <= is_vram;
				loc_pending <= !is_vram;
			end
			if (loc_pending) begin
				loc_ready <= 1'b1;
				o_pal_we <= o_wb_rw && loc_is_pal;
				if (o_wb_rw && !loc_is_pal) begin
					case (loc_offset)
						`CHUNKY_REG_VRAM_OFFSET: o_vram_offset <= o_wb_wdata;
						`CHUNKY_REG_CPU_OFFSET: cpu_offset <= o_wb_wdata;
						`CHUNKY_REG_CONTROL: o_frame_start <= o_wb_wdata[0];
						default: ;
					endcase
				end
			end
		end
	end

	// The write buffer request registers also hold local accesses
	always_ff @(posedge i_clock) begin
		if (take) begin
			o_wb_rw <= i_cpu_rw;
			o_wb_address <= i_cpu_address + cpu_offset;
			o_wb_wdata <= i_cpu_wdata;
			loc_is_pal <= i_cpu_address < `CHUNKY_REGS_BASE;
			loc_offset <= i_cpu_address - ((i_cpu_address < `CHUNKY_REGS_BASE) ?
				`CHUNKY_PALETTE_BASE : `CHUNKY_REGS_BASE);
		end
		if (loc_pending) begin
			o_pal_index <= loc_offset[9:2];
			o_pal_rgb <= o_wb_wdata[23:0];
			if (!loc_is_pal && loc_offset == `CHUNKY_REG_VRAM_OFFSET)
				loc_rdata <= o_vram_offset;
			else if (!loc_is_pal && loc_offset == `CHUNKY_REG_CPU_OFFSET)
				loc_rdata <= cpu_offset;
			else
				loc_rdata <= '0;
		end
	end

endmodule

`default_nettype wire

// ==== chunky_expand.sv ====
`default_nettype none
`timescale 1ns/10ps

module chunky_expand #(
	parameter int FRAME_PIXELS = 64
) (
	input wire i_clock,
	input wire i_rst_n,

	input wire i_pal_we,
	input wire chunky_pkg::pal_index_t i_pal_index,
	input wire chunky_pkg::rgb_t i_pal_rgb,

	input wire i_word_valid,
	input wire chunky_pkg::word_t i_word,
	output logic o_word_ready,

	output logic o_pixel_valid,
	output chunky_pkg::rgb_t o_pixel_rgb,
	input wire i_pixel_ready,

	output logic o_frame_done
);
	localparam int CW = $clog2(FRAME_PIXELS + 1);
	localparam logic [CW-1:0] LAST_PIXEL = CW'(FRAME_PIXELS - 1);

	chunky_pkg::rgb_t palette [256];
	chunky_pkg::word_t word_q;
	chunky_pkg::pal_index_t pal_addr;
	logic addr_valid;
	logic [1:0] left;
	logic advance;
	logic load;
	logic pixel_xfer;
	logic [CW-1:0] pixel_count;

	assign advance = !o_pixel_valid || i_pixel_ready; // Whole pipe freezes on a stall
	assign o_word_ready = advance && (left == 2'd0);
	assign load = i_word_valid && o_word_ready;
	assign pixel_xfer = o_pixel_valid && i_pixel_ready;
	assign o_frame_done = pixel_xfer && (pixel_count == LAST_PIXEL);

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			addr_valid <= 1'b0;
			left <= 2'd0;
			o_pixel_valid <= 1'b0;
			pixel_count <= '0;
		end else begin
			if (advance) begin
				o_pixel_valid <= addr_valid;
				if (left != 2'd0) begin
					addr_valid <= 1'b1;
					left <= left - 2'd1;
				end else if (load) begin
					addr_valid <= 1'b1;
					left <= 2'd3; // Three bytes still queued behind the first
				end else begin
					addr_valid <= 1'b0;
				end
			end
			if (pixel_xfer)
				pixel_count <= o_frame_done ? '0 : pixel_count + 1'b1;
		end
	end

	// Palette lookup output is the pixel register itself
	always_ff @(posedge i_clock) begin
		if (i_pal_we)
			palette[i_pal_index] <= i_pal_rgb;
		if (advance) begin
			o_pixel_rgb <= palette[pal_addr];
			if (left != 2'd0) begin
				pal_addr <= word_q[7:0];
				word_q <= word_q >> 8;
			end else if (load) begin
				pal_addr <= i_word[7:0];
				word_q <= i_word >> 8;
			end
		end
	end

endmodule

`default_nettype wire

// ==== chunky_fetch.sv ====
`default_nettype none
`timescale 1ns/10ps

module chunky_fetch #(
	parameter int FRAME_WIDTH = 16,
	parameter int FRAME_HEIGHT = 4,
	parameter int PITCH = 16
) (
	input wire i_clock,
	input wire i_rst_n,

	input wire i_frame_start,
	input wire chunky_pkg::addr_t i_vram_offset,

	output logic o_vram_request,
	output chunky_pkg::addr_t o_vram_address,
	input wire chunky_pkg::word_t i_vram_rdata,
	input wire i_vram_ready,

	output logic o_word_valid,
	output chunky_pkg::word_t o_word,
	input wire i_word_ready
);
	localparam int XW = $clog2(FRAME_WIDTH + 1);
	localparam int YW = $clog2(FRAME_HEIGHT + 1);
	localparam logic [XW-1:0] X_LAST = XW'(FRAME_WIDTH - 4);
	localparam logic [YW-1:0] Y_LAST = YW'(FRAME_HEIGHT - 1);

	chunky_pkg::fetch_state_t state;
	logic [XW-1:0] x;
	logic [YW-1:0] y;
	chunky_pkg::addr_t row_base;
	logic last_group;
	logic handed;

	assign last_group = (x == X_LAST) && (y == Y_LAST);
	assign handed = (state == chunky_pkg::HAND_OFF) && i_word_ready;

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state <= chunky_pkg::IDLE;
			x <= '0;
			y <= '0;
			o_vram_request <= 1'b0;
			o_word_valid <= 1'b0;
		end else begin
			case (state)
				chunky_pkg::IDLE: begin
					if (i_frame_start) begin
						x <= '0;
						y <= '0;
						state <= chunky_pkg::REQUEST;
					end
				end
				chunky_pkg::REQUEST: begin
					o_vram_request <= 1'b1;
					state <= chunky_pkg::WAIT;
				end
				chunky_pkg::WAIT: begin
					if (i_vram_ready) begin
						o_vram_request <= 1'b0;
						o_word_valid <= 1'b1;
						state <= chunky_pkg::HAND_OFF;
					end
				end
				chunky_pkg::HAND_OFF: begin
					if (i_word_ready) begin
						o_word_valid <= 1'b0;
						state <= last_group ? chunky_pkg::IDLE : chunky_pkg::REQUEST;
						if (x == X_LAST) begin
							x <= '0;
							y <= y + 1'b1;
						end else begin
							x <= x + XW'(4);
						end
					end
				end
			endcase
		end
	end

	// Row base tracks vram_offset + y * PITCH without a multiplier
	always_ff @(posedge i_clock) begin
		if (state == chunky_pkg::IDLE && i_frame_start)
			row_base <= i_vram_offset;
		else if (handed && x == X_LAST)
			row_base <= row_base + chunky_pkg::addr_t'(PITCH);
		if (state == chunky_pkg::REQUEST)
			o_vram_address <= row_base + chunky_pkg::addr_t'(x);
		if (state == chunky_pkg::WAIT && i_vram_ready)
			o_word <= i_vram_rdata;
	end

endmodule

`default_nettype wire

// ==== chunky_macros.svh ====
`ifndef CHUNKY_MACROS_SVH
`define CHUNKY_MACROS_SVH

// CPU address map with VRAM below the palette
`define CHUNKY_PALETTE_BASE 32'h0080_0000
`define CHUNKY_REGS_BASE 32'h0081_0000

// Register offsets from CHUNKY_REGS_BASE
`define CHUNKY_REG_VRAM_OFFSET 32'd0
`define CHUNKY_REG_CPU_OFFSET 32'd4
`define CHUNKY_REG_CONTROL 32'd8

// Depth of the VRAM model in 32-bit words
`define CHUNKY_VRAM_WORDS 1024

`endif

// ==== chunky_pkg.sv ====
`default_nettype none

package chunky_pkg;

	typedef logic [31:0] addr_t; // Byte address
	typedef logic [31:0] word_t; // Four pixel indices with the low byte first
	typedef logic [23:0] rgb_t;
	typedef logic [7:0] pal_index_t;

	typedef enum logic [1:0] {
		IDLE,
		REQUEST,
		WAIT,
		HAND_OFF
	} fetch_state_t;

	typedef enum logic [1:0] {
		EMPTY,
		WRITE,
		READ
	} wbuf_state_t;

endpackage

`default_nettype wire

// ==== chunky_tb.sv ====
`default_nettype none
`timescale 1ns/10ps
`include "chunky_macros.svh"

module chunky_tb;
	localparam int FRAME_WIDTH = 16;
	localparam int FRAME_HEIGHT = 4;
	localparam int PITCH = 16;
	localparam int FRAME_PIXELS = FRAME_WIDTH * FRAME_HEIGHT;
	localparam int FRAMES = 4;
	localparam int FILL_WORDS = 64;
	localparam int CPU_OFFSET_K = 32'h40;
	localparam int OFFSET_READS = FILL_WORDS - CPU_OFFSET_K / 4;
	localparam int CPU_ACCESSES = 5 + FILL_WORDS + 3 + OFFSET_READS + 257 + 2 * FRAMES + 1;
	localparam int TIMEOUT_CYCLES = 4 * (FRAMES * FRAME_PIXELS * 8 + CPU_ACCESSES * 8);
	localparam logic [31:0] SEED = 32'h9918_5351;

	logic i_clock;
	logic i_rst_n;
	logic i_cpu_request;
	logic i_cpu_rw;
	chunky_pkg::addr_t i_cpu_address;
	chunky_pkg::word_t i_cpu_wdata;
	chunky_pkg::word_t o_cpu_rdata;
	logic o_cpu_ready;
	logic o_pixel_valid;
	chunky_pkg::rgb_t o_pixel_rgb;
	logic i_pixel_ready;
	logic o_frame_done;

	chunky_pkg::word_t vram_shadow [`CHUNKY_VRAM_WORDS];
	chunky_pkg::rgb_t pal_shadow [256];
	logic [31:0] lfsr_state;
	logic ready_random;
	logic frame_active;
	chunky_pkg::addr_t frame_offset;
	int px;
	int py;
	int frames_seen;
	int cycle_count;

	chunky_video_top #(
		.FRAME_WIDTH(FRAME_WIDTH),
		.FRAME_HEIGHT(FRAME_HEIGHT),
		.PITCH(PITCH)
	) dut0 (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_cpu_request(i_cpu_request),
		.i_cpu_rw(i_cpu_rw),
		.i_cpu_address(i_cpu_address),
		.i_cpu_wdata(i_cpu_wdata),
		.o_cpu_rdata(o_cpu_rdata),
		.o_cpu_ready(o_cpu_ready),
		.o_pixel_valid(o_pixel_valid),
		.o_pixel_rgb(o_pixel_rgb),
		.i_pixel_ready(i_pixel_ready),
		.o_frame_done(o_frame_done)
	);

	initial begin
		i_clock = 1'b0;
		forever #20 i_clock = ~i_clock;
	end

	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]}; // x^32+x^22+x^2+x+1
	endfunction

	task automatic draw_bits(input int count, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < count; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			value = {value[30:0], lfsr_state[0]};
		end
	endtask

	// Colour of pixel (x, y) from the shadow VRAM and palette with little-endian bytes
	function automatic chunky_pkg::rgb_t expected_pixel(input chunky_pkg::addr_t offset,
			input int x, input int y);
		chunky_pkg::addr_t byte_addr;
		chunky_pkg::word_t word;
		chunky_pkg::pal_index_t index;
		byte_addr = offset + chunky_pkg::addr_t'(y * PITCH + x);
		word = vram_shadow[(byte_addr >> 2) % `CHUNKY_VRAM_WORDS];
		index = word[8 * byte_addr[1:0] +: 8];
		return pal_shadow[index];
	endfunction

	task automatic check_value(input string what, input logic [31:0] got,
			input logic [31:0] expected);
		if (got !== expected) begin
			$display("FAIL at %0t: %s is %h, expected %h", $time, what, got, expected);
			$display("SOME TESTS FAILED");
			$fatal(1, "Stopped at the first mismatch");
		end
	endtask

	task automatic cpu_access(input logic rw, input chunky_pkg::addr_t address,
			input chunky_pkg::word_t wdata, output chunky_pkg::word_t rdata);
		@(posedge i_clock);
		i_cpu_request <= 1'b1;
		i_cpu_rw <= rw;
		i_cpu_address <= address;
		i_cpu_wdata <= wdata;
		@(negedge i_clock);
		while (!o_cpu_ready)
			@(negedge i_clock);
		rdata = o_cpu_rdata;
		@(posedge i_clock);
		i_cpu_request <= 1'b0; // Request stays high through the ready cycle and drops after it
	endtask

	task automatic cpu_write(input chunky_pkg::addr_t address, input chunky_pkg::word_t wdata);
		chunky_pkg::word_t unused;
		cpu_access(1'b1, address, wdata, unused);
	endtask

	task automatic cpu_read(input chunky_pkg::addr_t address, output chunky_pkg::word_t rdata);
		cpu_access(1'b0, address, '0, rdata);
	endtask

	task automatic run_frame(input chunky_pkg::addr_t offset, input logic random_ready);
		int target;
		cpu_write(`CHUNKY_REGS_BASE + `CHUNKY_REG_VRAM_OFFSET, offset);
		@(negedge i_clock);
		frame_offset = offset;
		ready_random = random_ready;
		frame_active = 1'b1;
		target = frames_seen + 1;
		cpu_write(`CHUNKY_REGS_BASE + `CHUNKY_REG_CONTROL, 32'h1);
		while (frames_seen < target)
			@(negedge i_clock);
		ready_random = 1'b0;
	endtask

	always @(posedge i_clock) begin
		if (ready_random) begin
			lfsr_state = lfsr_step(lfsr_state);
			i_pixel_ready <= lfsr_state[0];
		end else begin
			i_pixel_ready <= 1'b1;
		end
	end

	// A transfer seen at the falling edge completes at the next rising edge
	always @(negedge i_clock) begin
		if (i_rst_n && o_pixel_valid && i_pixel_ready) begin
			check_value("pixel inside an active frame", frame_active, 1'b1);
			check_value($sformatf("pixel (%0d,%0d)", px, py), o_pixel_rgb,
				expected_pixel(frame_offset, px, py));
			check_value("frame done flag", o_frame_done,
				(px == FRAME_WIDTH - 1) && (py == FRAME_HEIGHT - 1));
			if (px == FRAME_WIDTH - 1) begin
				px = 0;
				if (py == FRAME_HEIGHT - 1) begin
					py = 0;
					frames_seen++;
					frame_active = 1'b0;
				end else begin
					py++;
				end
			end else begin
				px++;
			end
		end
	end

	always @(posedge i_clock) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("SOME TESTS FAILED");
			$fatal(1, "Cycle limit reached");
		end
	end

	initial begin
		chunky_pkg::word_t data;
		chunky_pkg::pal_index_t index;
		logic [31:0] upper;
		i_rst_n = 1'b0;
		i_cpu_request = 1'b0;
		i_cpu_rw = 1'b0;
		i_cpu_address = '0;
		i_cpu_wdata = '0;
		i_pixel_ready = 1'b0;
		lfsr_state = SEED;
		ready_random = 1'b0;
		frame_active = 1'b0;
		frame_offset = '0;
		px = 0;
		py = 0;
		frames_seen = 0;
		cycle_count = 0;
		for (int i = 0; i < `CHUNKY_VRAM_WORDS; i++)
			vram_shadow[i] = '0;
		repeat (2) @(posedge i_clock);
		i_rst_n <= 1'b1;

		cpu_write(`CHUNKY_REGS_BASE + `CHUNKY_REG_VRAM_OFFSET, 32'h0000_0080);
		cpu_read(`CHUNKY_REGS_BASE + `CHUNKY_REG_VRAM_OFFSET, data);
		check_value("vram_offset readback", data, 32'h0000_0080);
		cpu_write(`CHUNKY_REGS_BASE + `CHUNKY_REG_CPU_OFFSET, 32'h0000_0120);
		cpu_read(`CHUNKY_REGS_BASE + `CHUNKY_REG_CPU_OFFSET, data);
		check_value("cpu_offset readback", data, 32'h0000_0120);
		cpu_write(`CHUNKY_REGS_BASE + `CHUNKY_REG_CPU_OFFSET, 32'h0);

		for (int i = 0; i < FILL_WORDS; i++) begin
			draw_bits(32, data);
			cpu_write(chunky_pkg::addr_t'(i * 4), data);
			vram_shadow[i] = data;
		end

		// Reads land at A - K + K, so each one returns the word written at A
		cpu_write(`CHUNKY_REGS_BASE + `CHUNKY_REG_CPU_OFFSET, CPU_OFFSET_K);
		for (int a = CPU_OFFSET_K; a < FILL_WORDS * 4; a += 4) begin
			cpu_read(chunky_pkg::addr_t'(a - CPU_OFFSET_K), data);
			check_value($sformatf("VRAM word at %h", a), data, vram_shadow[a / 4]);
		end
		cpu_write(`CHUNKY_REGS_BASE + `CHUNKY_REG_CPU_OFFSET, 32'h0);
		cpu_read(`CHUNKY_REGS_BASE + `CHUNKY_REG_CPU_OFFSET, data);
		check_value("cpu_offset cleared", data, 32'h0);

		for (int i = 0; i < 256; i++) begin
			draw_bits(24, data);
			cpu_write(`CHUNKY_PALETTE_BASE + chunky_pkg::addr_t'(i * 4), data);
			pal_shadow[i] = data[23:0];
		end
		cpu_read(`CHUNKY_PALETTE_BASE + 32'h14, data);
		check_value("palette region read", data, 32'h0);

		run_frame(32'h0, 1'b0);
		run_frame(32'h80, 1'b0);
		run_frame(32'h40, 1'b1);

		// First pixel of the next frame uses this entry
		index = vram_shadow[CPU_OFFSET_K / 4][7:0];
		draw_bits(8, upper);
		draw_bits(24, data);
		cpu_write(`CHUNKY_PALETTE_BASE + chunky_pkg::addr_t'(index) * 4,
			{upper[7:0] | 8'h01, data[23:0]});
		pal_shadow[index] = data[23:0];
		run_frame(32'h40, 1'b0);

		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== chunky_video_top.sv ====
`default_nettype none
`timescale 1ns/10ps

module chunky_video_top #(
	parameter int FRAME_WIDTH = 16,
	parameter int FRAME_HEIGHT = 4,
	parameter int PITCH = 16
) (
	input wire i_clock,
	input wire i_rst_n,

	input wire i_cpu_request,
	input wire i_cpu_rw,
	input wire chunky_pkg::addr_t i_cpu_address,
	input wire chunky_pkg::word_t i_cpu_wdata,
	output chunky_pkg::word_t o_cpu_rdata,
	output logic o_cpu_ready,

	output logic o_pixel_valid,
	output chunky_pkg::rgb_t o_pixel_rgb,
	input wire i_pixel_ready,
	output logic o_frame_done
);
	logic wb_request;
	logic wb_rw;
	chunky_pkg::addr_t wb_address;
	chunky_pkg::word_t wb_wdata;
	chunky_pkg::word_t wb_rdata;
	logic wb_ready;

	logic pa_request;
	logic pa_rw;
	chunky_pkg::addr_t pa_address;
	chunky_pkg::word_t pa_wdata;
	chunky_pkg::word_t pa_rdata;
	logic pa_ready;

	logic pb_request;
	chunky_pkg::addr_t pb_address;
	chunky_pkg::word_t pb_rdata;
	logic pb_ready;

	logic pal_we;
	chunky_pkg::pal_index_t pal_index;
	chunky_pkg::rgb_t pal_rgb;
	chunky_pkg::addr_t vram_offset;
	logic frame_start;

	logic word_valid;
	chunky_pkg::word_t word;
	logic word_ready;

	chunky_cpu_port cpu_port0 (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_cpu_request(i_cpu_request),
		.i_cpu_rw(i_cpu_rw),
		.i_cpu_address(i_cpu_address),
		.i_cpu_wdata(i_cpu_wdata),
		.o_cpu_rdata(o_cpu_rdata),
		.o_cpu_ready(o_cpu_ready),
		.o_wb_request(wb_request),
		.o_wb_rw(wb_rw),
		.o_wb_address(wb_address),
		.o_wb_wdata(wb_wdata),
		.i_wb_rdata(wb_rdata),
		.i_wb_ready(wb_ready),
		.o_pal_we(pal_we),
		.o_pal_index(pal_index),
		.o_pal_rgb(pal_rgb),
		.o_vram_offset(vram_offset),
		.o_frame_start(frame_start)
	);

	vram_write_buffer wbuf0 (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_request(wb_request),
		.i_rw(wb_rw),
		.i_address(wb_address),
		.i_wdata(wb_wdata),
		.o_rdata(wb_rdata),
		.o_ready(wb_ready),
		.o_bus_request(pa_request),
		.o_bus_rw(pa_rw),
		.o_bus_address(pa_address),
		.o_bus_wdata(pa_wdata),
		.i_bus_rdata(pa_rdata),
		.i_bus_ready(pa_ready)
	);

	// Port B only feeds the raster fetch
	vram_dual vram0 (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_pa_request(pa_request),
		.i_pa_rw(pa_rw),
		.i_pa_address(pa_address),
		.i_pa_wdata(pa_wdata),
		.o_pa_rdata(pa_rdata),
		.o_pa_ready(pa_ready),
		.i_pb_request(pb_request),
		.i_pb_rw(1'b0),
		.i_pb_address(pb_address),
		.i_pb_wdata('0),
		.o_pb_rdata(pb_rdata),
		.o_pb_ready(pb_ready)
	);

	chunky_fetch #(
		.FRAME_WIDTH(FRAME_WIDTH),
		.FRAME_HEIGHT(FRAME_HEIGHT),
		.PITCH(PITCH)
	) fetch0 (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_frame_start(frame_start),
		.i_vram_offset(vram_offset),
		.o_vram_request(pb_request),
		.o_vram_address(pb_address),
		.i_vram_rdata(pb_rdata),
		.i_vram_ready(pb_ready),
		.o_word_valid(word_valid),
		.o_word(word),
		.i_word_ready(word_ready)
	);

	chunky_expand #(
		.FRAME_PIXELS(FRAME_WIDTH * FRAME_HEIGHT)
	) expand0 (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_pal_we(pal_we),
		.i_pal_index(pal_index),
		.i_pal_rgb(pal_rgb),
		.i_word_valid(word_valid),
		.i_word(word),
		.o_word_ready(word_ready),
		.o_pixel_valid(o_pixel_valid),
		.o_pixel_rgb(o_pixel_rgb),
		.i_pixel_ready(i_pixel_ready),
		.o_frame_done(o_frame_done)
	);

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+.
chunky_pkg.sv
vram_dual.sv
vram_write_buffer.sv
chunky_cpu_port.sv
chunky_fetch.sv
chunky_expand.sv
chunky_video_top.sv
chunky_chk.sv
chunky_tb.sv

// ==== vram_dual.sv ====
`default_nettype none
`timescale 1ns/10ps
`include "chunky_macros.svh"

module vram_dual (
	input wire i_clock,
	input wire i_rst_n,

	input wire i_pa_request,
	input wire i_pa_rw,
	input wire chunky_pkg::addr_t i_pa_address,
	input wire chunky_pkg::word_t i_pa_wdata,
	output chunky_pkg::word_t o_pa_rdata,
	output logic o_pa_ready,

	input wire i_pb_request,
	input wire i_pb_rw,
	input wire chunky_pkg::addr_t i_pb_address,
	input wire chunky_pkg::word_t i_pb_wdata,
	output chunky_pkg::word_t o_pb_rdata,
	output logic o_pb_ready
);
	localparam int AW = $clog2(`CHUNKY_VRAM_WORDS);

	chunky_pkg::word_t mem [`CHUNKY_VRAM_WORDS];
	logic [AW-1:0] pa_index;
	logic [AW-1:0] pb_index;
	logic pa_take;
	logic pb_take;

	assign pa_index = i_pa_address[AW+1:2];
	assign pb_index = i_pb_address[AW+1:2];
	assign pa_take = i_pa_request && !o_pa_ready; // Held request is ignored in the ready cycle
	assign pb_take = i_pb_request && !o_pb_ready;

	always_ff @(posedge i_clock) begin
		if (pa_take) begin
			if (i_pa_rw)
				mem[pa_index] <= i_pa_wdata;
			else
				o_pa_rdata <= mem[pa_index];
		end
		if (pb_take) begin
			if (i_pb_rw)
				mem[pb_index] <= i_pb_wdata; // Port B wins on a same-word collision
			else
				o_pb_rdata <= mem[pb_index];
		end
	end

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_pa_ready <= 1'b0;
			o_pb_ready <= 1'b0;
		end else begin
			o_pa_ready <= pa_take;
			o_pb_ready <= pb_take;
		end
	end

endmodule

`default_nettype wire

// ==== vram_write_buffer.sv ====
`default_nettype none
`timescale 1ns/10ps

module vram_write_buffer (
	input wire i_clock,
	input wire i_rst_n,

	input wire i_request,
	input wire i_rw,
	input wire chunky_pkg::addr_t i_address,
	input wire chunky_pkg::word_t i_wdata,
	output chunky_pkg::word_t o_rdata,
	output logic o_ready,

	output logic o_bus_request,
	output logic o_bus_rw,
	output chunky_pkg::addr_t o_bus_address,
	output chunky_pkg::word_t o_bus_wdata,
	input wire chunky_pkg::word_t i_bus_rdata,
	input wire i_bus_ready
);
	chunky_pkg::wbuf_state_t state;
	logic accept;

	// A new access is only taken once the previous write has drained
	assign accept = (state == chunky_pkg::EMPTY) && i_request && !o_ready;

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state <= chunky_pkg::EMPTY;
			o_ready <= 1'b0;
			o_bus_request <= 1'b0;
		end else begin
			o_ready <= 1'b0;
			case (state)
				chunky_pkg::EMPTY: begin
					if (accept) begin
						o_bus_request <= 1'b1;
						o_ready <= i_rw; // Writes are acknowledged at capture
						state <= i_rw ? chunky_pkg::WRITE : chunky_pkg::READ;
					end
				end
				chunky_pkg::WRITE: begin
					if (i_bus_ready) begin
						o_bus_request <= 1'b0;
						state <= chunky_pkg::EMPTY;
					end
				end
				chunky_pkg::READ: begin
					if (i_bus_ready) begin
						o_bus_request <= 1'b0;
						o_ready <= 1'b1;
						state <= chunky_pkg::EMPTY;
					end
				end
				default: state <= chunky_pkg::EMPTY;
			endcase
		end
	end

	always_ff @(posedge i_clock) begin
		if (accept) begin
			o_bus_rw <= i_rw;
			o_bus_address <= i_address;
			o_bus_wdata <= i_wdata;
		end
		if (state == chunky_pkg::READ && i_bus_ready)
			o_rdata <= i_bus_rdata;
	end

endmodule

`default_nettype wire
